/* hw/knn_cfg_pkg.sv */
// Default sizes of the point-selection stage, passed down as parameters by the top level
package knn_cfg_pkg;

    // ==================================================
    // Sort list and point sizes
    // ==================================================
    // List length is 2**SORT_LEN_WIDTH
    localparam int SORT_LEN_WIDTH_DEF = 2;
    // Point index width, 64 points
    localparam int IDX_WIDTH_DEF = 6;
    localparam int DIST_WIDTH_DEF = 8;

    // ==================================================
    // Core count and memory word
    // ==================================================
    localparam int NUM_SORT_CORE_DEF = 4;
    // Mask word and output map word share this width
    localparam int SRAM_WIDTH_DEF = 64;

endpackage

/* hw/knn_types_pkg.sv */
// State encodings for the sort cores and the output serializer
package knn_types_pkg;

    // Sort core collects candidates, then holds its list until taken
    typedef enum logic {
        SORT_COLLECT,
        SORT_HOLD
    } sort_state_e;

    // Serializer waits for a load, then shifts words out
    typedef enum logic {
        PISO_IDLE,
        PISO_SHIFT
    } piso_state_e;

endpackage

/* hw/ins_sorter.sv */
// Insertion-sort core that keeps the SORT_LEN nearest points offered to it, one per instance
`timescale 1ns/1ns
module ins_sorter
    import knn_cfg_pkg::*;
    import knn_types_pkg::*;
#(
    parameter int SORT_LEN_WIDTH = SORT_LEN_WIDTH_DEF,
    parameter int IDX_WIDTH      = IDX_WIDTH_DEF,
    parameter int DIST_WIDTH     = DIST_WIDTH_DEF,
    localparam int SORT_LEN      = 2**SORT_LEN_WIDTH
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [DIST_WIDTH-1:0]         cand_dist,
    input  logic [IDX_WIDTH-1:0]          cand_idx,
    input  logic                          cand_ins,
    input  logic                          cand_last,
    input  logic                          cand_vld,
    output logic                          cand_rdy,
    output logic [IDX_WIDTH*SORT_LEN-1:0] res_idx,
    output logic                          res_vld,
    input  logic                          res_rdy
);

    // ==================================================
    // List storage, entry 0 is the nearest
    // ==================================================
    sort_state_e                           state;
    logic [SORT_LEN-1:0][DIST_WIDTH-1:0]   dist_q;
    logic [SORT_LEN-1:0][IDX_WIDTH-1:0]    idx_q;
    logic [SORT_LEN-1:0]                   ent_vld;

    // Next list after an insert
    logic [SORT_LEN-1:0][DIST_WIDTH-1:0]   nxt_dist;
    logic [SORT_LEN-1:0][IDX_WIDTH-1:0]    nxt_idx;
    logic [SORT_LEN-1:0]                   nxt_vld;
    // Entry is strictly farther than the candidate, or empty
    logic [SORT_LEN-1:0]                   gt;
    logic                                  cand_fire;

    assign cand_rdy  = (state == SORT_COLLECT);
    assign res_vld   = (state == SORT_HOLD);
    assign res_idx   = idx_q;
    assign cand_fire = cand_vld && cand_rdy;

    // ==================================================
    // Insert position and shifted list
    // ==================================================
    always_comb begin
        for (int j = 0; j < SORT_LEN; j++) begin
            gt[j] = !ent_vld[j] || (cand_dist < dist_q[j]);
        end

        // Slot 0 takes the candidate whenever it is farther
        nxt_dist[0] = gt[0] ? cand_dist : dist_q[0];
        nxt_idx[0]  = gt[0] ? cand_idx  : idx_q[0];
        nxt_vld[0]  = gt[0] | ent_vld[0];

        for (int j = 1; j < SORT_LEN; j++) begin
            if (!gt[j]) begin
                // Nearer or equal, stays in place so ties keep arrival order
                nxt_dist[j] = dist_q[j];
                nxt_idx[j]  = idx_q[j];
                nxt_vld[j]  = ent_vld[j];
            end else if (!gt[j-1]) begin
                // First farther entry
                nxt_dist[j] = cand_dist;
                nxt_idx[j]  = cand_idx;
                nxt_vld[j]  = 1'b1;
            end else begin
                // Behind the insert point, move down one
                nxt_dist[j] = dist_q[j-1];
                nxt_idx[j]  = idx_q[j-1];
                nxt_vld[j]  = ent_vld[j-1];
            end
        end
    end

    // ==================================================
    // State machine and list update
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SORT_COLLECT;
            ent_vld <= '0;
            dist_q  <= '1;
            idx_q   <= '1;
        end else begin
            case (state)
                SORT_COLLECT: begin
                    if (cand_fire) begin
                        // Clear mask bit still passes the last flag
                        if (cand_ins) begin
                            dist_q  <= nxt_dist;
                            idx_q   <= nxt_idx;
                            ent_vld <= nxt_vld;
                        end
                        if (cand_last) begin
                            state <= SORT_HOLD;
                        end
                    end
                end
                SORT_HOLD: begin
                    // List taken, refill with empty entries
                    if (res_rdy) begin
                        state   <= SORT_COLLECT;
                        ent_vld <= '0;
                        dist_q  <= '1;
                        idx_q   <= '1;
                    end
                end
                default: state <= SORT_COLLECT;
            endcase
        end
    end

endmodule

/* hw/piso.sv */
// Serializer that loads one wide word and sends it out as narrow words, lowest first
`timescale 1ns/1ns
module piso
    import knn_cfg_pkg::*;
    import knn_types_pkg::*;
#(
    parameter int IN_WIDTH  = SRAM_WIDTH_DEF*NUM_SORT_CORE_DEF,
    parameter int OUT_WIDTH = SRAM_WIDTH_DEF
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [IN_WIDTH-1:0]  in_dat,
    input  logic                 in_vld,
    output logic                 in_rdy,
    output logic [OUT_WIDTH-1:0] out_dat,
    output logic                 out_vld,
    input  logic                 out_rdy
);

    localparam int NUM_WORDS = IN_WIDTH/OUT_WIDTH;
    localparam int CNT_WIDTH = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

    piso_state_e            state;
    logic [IN_WIDTH-1:0]    shreg;
    // Words already sent
    logic [CNT_WIDTH-1:0]   cnt;

    assign in_rdy  = (state == PISO_IDLE);
    assign out_vld = (state == PISO_SHIFT);
    assign out_dat = shreg[OUT_WIDTH-1:0];

    // Control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PISO_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                PISO_IDLE: begin
                    if (in_vld) begin
                        state <= PISO_SHIFT;
                        cnt   <= '0;
                    end
                end
                PISO_SHIFT: begin
                    if (out_rdy) begin
                        if (cnt == CNT_WIDTH'(NUM_WORDS-1)) begin
                            state <= PISO_IDLE;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                default: state <= PISO_IDLE;
            endcase
        end
    end

    // Shift register, next word drops to the bottom on each accept
    always_ff @(posedge clk) begin
        if (in_vld && in_rdy) begin
            shreg <= in_dat;
        end else if (out_vld && out_rdy) begin
            shreg <= shreg >> OUT_WIDTH;
        end
    end

endmodule

/* hw/mask_ram.sv */
// Mask memory with a write port for loading and a one-cycle read port with valid/ready
`timescale 1ns/1ns
module mask_ram
    import knn_cfg_pkg::*;
#(
    parameter int IDX_WIDTH        = IDX_WIDTH_DEF,
    parameter int NUM_SORT_CORE    = NUM_SORT_CORE_DEF,
    parameter int SRAM_WIDTH       = SRAM_WIDTH_DEF,
    localparam int MASK_ADDR_WIDTH = $clog2((2**IDX_WIDTH)*NUM_SORT_CORE/SRAM_WIDTH)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // Load port
    input  logic                       wr_en,
    input  logic [MASK_ADDR_WIDTH-1:0] wr_addr,
    input  logic [SRAM_WIDTH-1:0]      wr_dat,
    // Read port
    input  logic [MASK_ADDR_WIDTH-1:0] rd_addr,
    input  logic                       rd_addr_vld,
    output logic                       rd_addr_rdy,
    output logic [SRAM_WIDTH-1:0]      rd_dat,
    output logic                       rd_dat_vld,
    input  logic                       rd_dat_rdy
);

    logic [SRAM_WIDTH-1:0] mem [2**MASK_ADDR_WIDTH];
    logic                  rd_fire;

    // New address only when the held word leaves this cycle or none is held
    assign rd_addr_rdy = !rd_dat_vld || rd_dat_rdy;
    assign rd_fire     = rd_addr_vld && rd_addr_rdy;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_dat;
        end
    end

    // Output holding stage
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_dat <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_dat_vld <= 1'b0;
        end else if (rd_fire) begin
            rd_dat_vld <= 1'b1;
        end else if (rd_dat_rdy) begin
            rd_dat_vld <= 1'b0;
        end
    end

endmodule

/* hw/pss.sv */
// Point-selection stage: looks up the mask, feeds the sort cores and serializes their lists
`timescale 1ns/1ns
module pss
    import knn_cfg_pkg::*;
#(
    parameter int SORT_LEN_WIDTH   = SORT_LEN_WIDTH_DEF,
    parameter int IDX_WIDTH        = IDX_WIDTH_DEF,
    parameter int DIST_WIDTH       = DIST_WIDTH_DEF,
    parameter int NUM_SORT_CORE    = NUM_SORT_CORE_DEF,
    parameter int SRAM_WIDTH       = SRAM_WIDTH_DEF,
    localparam int MASK_ADDR_WIDTH = $clog2((2**IDX_WIDTH)*NUM_SORT_CORE/SRAM_WIDTH)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // Candidate stream
    input  logic [IDX_WIDTH-1:0]       lop_idx,
    input  logic [DIST_WIDTH-1:0]      lop_dist,
    input  logic                       lop_last,
    input  logic [IDX_WIDTH-1:0]       cp_idx,
    input  logic                       lop_vld,
    output logic                       lop_rdy,
    // Mask read
    output logic [MASK_ADDR_WIDTH-1:0] rd_addr,
    output logic                       rd_addr_vld,
    input  logic                       rd_addr_rdy,
    input  logic [SRAM_WIDTH-1:0]      rd_dat,
    input  logic                       rd_dat_vld,
    output logic                       rd_dat_rdy,
    // Map output
    output logic [SRAM_WIDTH-1:0]      map,
    output logic                       map_vld,
    input  logic                       map_rdy
);

    // ==================================================
    // Derived sizes and signals
    // ==================================================
    localparam int SORT_LEN     = 2**SORT_LEN_WIDTH;
    localparam int PTS_PER_WORD = SRAM_WIDTH/NUM_SORT_CORE;
    localparam int OFF_WIDTH    = $clog2(PTS_PER_WORD);
    localparam int LIST_WIDTH   = IDX_WIDTH*SORT_LEN;

    // Data stage copy of the accepted candidate
    logic [DIST_WIDTH-1:0]             dist_q;
    logic [IDX_WIDTH-1:0]              idx_q;
    logic                              last_q;
    logic [OFF_WIDTH-1:0]              off_q;
    logic [IDX_WIDTH-1:0]              cp_q;
    // Center index of the frame being held
    logic [IDX_WIDTH-1:0]              cp_hold;

    logic                              lop_fire;
    logic                              core_rdy;
    logic                              any_hold;
    logic                              all_res;
    logic                              res_take;
    logic                              piso_in_rdy;
    logic [NUM_SORT_CORE-1:0]          cand_ins;
    logic [NUM_SORT_CORE-1:0]          cand_rdy;
    logic [NUM_SORT_CORE-1:0]          res_vld;
    logic [LIST_WIDTH-1:0]             res_idx [NUM_SORT_CORE];
    logic [SRAM_WIDTH*NUM_SORT_CORE-1:0] pack_dat;

    // ==================================================
    // Handshakes
    // ==================================================
    // Every core is offered the data word, so each must be ready
    assign core_rdy = &(~{NUM_SORT_CORE{rd_dat_vld}} | cand_rdy);
    assign any_hold = |res_vld;
    assign all_res  = &res_vld;

    assign lop_rdy     = rd_addr_rdy && core_rdy && !any_hold;
    assign lop_fire    = lop_vld && lop_rdy;
    assign rd_addr_vld = lop_fire;
    // Word address, one mask word covers PTS_PER_WORD points
    assign rd_addr     = MASK_ADDR_WIDTH'(lop_idx >> OFF_WIDTH);
    assign rd_dat_rdy  = core_rdy;

    // Piso takes all lists at once and frees every core
    assign res_take = all_res && piso_in_rdy;

    // Candidate moves to the data stage together with its mask read
    always_ff @(posedge clk) begin
        if (lop_fire) begin
            dist_q <= lop_dist;
            idx_q  <= lop_idx;
            last_q <= lop_last;
            off_q  <= lop_idx[OFF_WIDTH-1:0];
            cp_q   <= cp_idx;
        end
    end

    // Center index kept until piso has loaded the lists
    always_ff @(posedge clk) begin
        if (rd_dat_vld && core_rdy && last_q) begin
            cp_hold <= cp_q;
        end
    end

    // ==================================================
    // Sort cores and packing
    // ==================================================
    for (genvar i = 0; i < NUM_SORT_CORE; i++) begin : g_core
        // Bit of core i inside the offset's group
        assign cand_ins[i] = rd_dat[NUM_SORT_CORE*off_q + i];

        ins_sorter #(
            .SORT_LEN_WIDTH (SORT_LEN_WIDTH),
            .IDX_WIDTH      (IDX_WIDTH),
            .DIST_WIDTH     (DIST_WIDTH)
        ) u_sorter (
            .clk       (clk),
            .rst_n     (rst_n),
            .cand_dist (dist_q),
            .cand_idx  (idx_q),
            .cand_ins  (cand_ins[i]),
            .cand_last (last_q),
            .cand_vld  (rd_dat_vld),
            .cand_rdy  (cand_rdy[i]),
            .res_idx   (res_idx[i]),
            .res_vld   (res_vld[i]),
            .res_rdy   (res_take)
        );

        // Center index above the list, zero fill on top
        assign pack_dat[SRAM_WIDTH*i +: SRAM_WIDTH] = SRAM_WIDTH'({cp_hold, res_idx[i]});
    end

    piso #(
        .IN_WIDTH  (SRAM_WIDTH*NUM_SORT_CORE),
        .OUT_WIDTH (SRAM_WIDTH)
    ) u_piso (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_dat  (pack_dat),
        .in_vld  (all_res),
        .in_rdy  (piso_in_rdy),
        .out_dat (map),
        .out_vld (map_vld),
        .out_rdy (map_rdy)
    );

endmodule

/* hw/knn_sort_top.sv */
// Top level of the kNN point-selection stage; joins the selection logic and the mask memory
`timescale 1ns/1ns
module knn_sort_top
    import knn_cfg_pkg::*;
#(
    parameter int SORT_LEN_WIDTH   = SORT_LEN_WIDTH_DEF,
    parameter int IDX_WIDTH        = IDX_WIDTH_DEF,
    parameter int DIST_WIDTH       = DIST_WIDTH_DEF,
    parameter int NUM_SORT_CORE    = NUM_SORT_CORE_DEF,
    parameter int SRAM_WIDTH       = SRAM_WIDTH_DEF,
    localparam int MASK_ADDR_WIDTH = $clog2((2**IDX_WIDTH)*NUM_SORT_CORE/SRAM_WIDTH)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // Mask load, only between frames
    input  logic                       mask_wr_en,
    input  logic [MASK_ADDR_WIDTH-1:0] mask_wr_addr,
    input  logic [SRAM_WIDTH-1:0]      mask_wr_data,
    // Candidates of one center point
    input  logic [IDX_WIDTH-1:0]       lop_idx,
    input  logic [DIST_WIDTH-1:0]      lop_dist,
    input  logic                       lop_last,
    input  logic [IDX_WIDTH-1:0]       cp_idx,
    input  logic                       lop_vld,
    output logic                       lop_rdy,
    // GLB map words
    output logic [SRAM_WIDTH-1:0]      map,
    output logic                       map_vld,
    input  logic                       map_rdy
);

    logic [MASK_ADDR_WIDTH-1:0] rd_addr;
    logic                       rd_addr_vld;
    logic                       rd_addr_rdy;
    logic [SRAM_WIDTH-1:0]      rd_dat;
    logic                       rd_dat_vld;
    logic                       rd_dat_rdy;

    pss #(
        .SORT_LEN_WIDTH (SORT_LEN_WIDTH),
        .IDX_WIDTH      (IDX_WIDTH),
        .DIST_WIDTH     (DIST_WIDTH),
        .NUM_SORT_CORE  (NUM_SORT_CORE),
        .SRAM_WIDTH     (SRAM_WIDTH)
    ) u_pss (
        .clk         (clk),
        .rst_n       (rst_n),
        .lop_idx     (lop_idx),
        .lop_dist    (lop_dist),
        .lop_last    (lop_last),
        .cp_idx      (cp_idx),
        .lop_vld     (lop_vld),
        .lop_rdy     (lop_rdy),
        .rd_addr     (rd_addr),
        .rd_addr_vld (rd_addr_vld),
        .rd_addr_rdy (rd_addr_rdy),
        .rd_dat      (rd_dat),
        .rd_dat_vld  (rd_dat_vld),
        .rd_dat_rdy  (rd_dat_rdy),
        .map         (map),
        .map_vld     (map_vld),
        .map_rdy     (map_rdy)
    );

    mask_ram #(
        .IDX_WIDTH     (IDX_WIDTH),
        .NUM_SORT_CORE (NUM_SORT_CORE),
        .SRAM_WIDTH    (SRAM_WIDTH)
    ) u_mask_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (mask_wr_en),
        .wr_addr     (mask_wr_addr),
        .wr_dat      (mask_wr_data),
        .rd_addr     (rd_addr),
        .rd_addr_vld (rd_addr_vld),
        .rd_addr_rdy (rd_addr_rdy),
        .rd_dat      (rd_dat),
        .rd_dat_vld  (rd_dat_vld),
        .rd_dat_rdy  (rd_dat_rdy)
    );

endmodule

/* sim/knn_sort_checker.sv */
// Testbench monitor; compares each map word of the DUT with the queue of expected words
`timescale 1ns/1ns
module knn_sort_checker #(
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] map,
    input  logic             map_vld,
    input  logic             map_rdy
);

    // ==================================================
    // Expected words and counters
    // ==================================================
    logic [WIDTH-1:0] exp_q [$];
    logic [WIDTH-1:0] exp_w;
    int               errors  = 0;
    int               checked = 0;

    // Queued in core order by the reference model
    task automatic expect_word(input logic [WIDTH-1:0] w);
        exp_q.push_back(w);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // Anything left at the end never came out of the DUT
    task automatic flush_missing();
        while (exp_q.size() > 0) begin
            exp_w = exp_q.pop_front();
            $display("Missing map word: %h was expected but never arrived", exp_w);
            errors++;
        end
    endtask

    // ==================================================
    // Compare
    // ==================================================
    // Mid-cycle sample, the word moves on the next rising edge
    always @(negedge clk) begin
        if (rst_n && map_vld && map_rdy) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected map word %h at %0t ns", map, $time);
                errors++;
            end else begin
                exp_w = exp_q.pop_front();
                checked++;
                if (map !== exp_w) begin
                    $display("** Error at %0t ns: map expected %h, actual %h",
                             $time, exp_w, map);
                    errors++;
                end
            end
        end
    end

endmodule

/* sim/tb_knn_sort.sv */
// Testbench for the kNN point-selection stage; runs a frame table and checks every map word
`timescale 1ns/1ns
module tb_knn_sort
    import knn_cfg_pkg::*;
();

    // ==================================================
    // Sizes, table and signals
    // ==================================================
    localparam int SORT_LEN    = 2**SORT_LEN_WIDTH_DEF;
    localparam int PTS         = SRAM_WIDTH_DEF/NUM_SORT_CORE_DEF;
    localparam int MASK_WORDS  = (2**IDX_WIDTH_DEF)*NUM_SORT_CORE_DEF/SRAM_WIDTH_DEF;
    localparam int MASK_ADDR_W = $clog2(MASK_WORDS);
    localparam int CAND_W      = IDX_WIDTH_DEF+DIST_WIDTH_DEF;
    localparam int NF          = 6;
    localparam int MAXC        = 10;
    localparam int TIMEOUT     = 2000;
    localparam int RNG_SEED    = 9289;

    // Mask patterns, point p sits at bit 4*(p%16)+core of word p/16
    localparam logic [63:0] ALL  = 64'hFFFF_FFFF_FFFF_FFFF;
    // Core p%4 owns point p
    localparam logic [63:0] DISJ = 64'h8421_8421_8421_8421;
    localparam logic [63:0] MIX0 = 64'h0F1E_2D3C_4B5A_6978;
    localparam logic [63:0] MIX1 = 64'hF0E1_D2C3_B4A5_9687;
    localparam logic [63:0] MIX2 = 64'h3355_AACC_0FF0_1248;
    localparam logic [63:0] MIX3 = 64'h8421_7777_0000_FFFF;

    // Frame table, candidate is {index, distance}
    logic [SRAM_WIDTH_DEF-1:0] f_mask [NF][MASK_WORDS];
    logic [IDX_WIDTH_DEF-1:0]  f_cp [NF];
    int                        f_stall [NF];
    int                        f_n [NF];
    logic [CAND_W-1:0]         f_cand [NF][MAXC];

    logic                      clk;
    logic                      rst_n;
    logic                      mask_wr_en;
    logic [MASK_ADDR_W-1:0]    mask_wr_addr;
    logic [SRAM_WIDTH_DEF-1:0] mask_wr_data;
    logic [IDX_WIDTH_DEF-1:0]  lop_idx;
    logic [DIST_WIDTH_DEF-1:0] lop_dist;
    logic                      lop_last;
    logic [IDX_WIDTH_DEF-1:0]  cp_idx;
    logic                      lop_vld;
    logic                      lop_rdy;
    logic [SRAM_WIDTH_DEF-1:0] map;
    logic                      map_vld;
    logic                      map_rdy;
    // Percent of cycles with map_rdy low
    int                        stall_pct = 0;
    int                        timeouts  = 0;

    knn_sort_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .mask_wr_en   (mask_wr_en),
        .mask_wr_addr (mask_wr_addr),
        .mask_wr_data (mask_wr_data),
        .lop_idx      (lop_idx),
        .lop_dist     (lop_dist),
        .lop_last     (lop_last),
        .cp_idx       (cp_idx),
        .lop_vld      (lop_vld),
        .lop_rdy      (lop_rdy),
        .map          (map),
        .map_vld      (map_vld),
        .map_rdy      (map_rdy)
    );

    knn_sort_checker #(.WIDTH(SRAM_WIDTH_DEF)) chk0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .map     (map),
        .map_vld (map_vld),
        .map_rdy (map_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Random back-pressure on the map output
    initial begin
        int roll;
        map_rdy = 1'b0;
        roll = int'($urandom(RNG_SEED));
        forever begin
            @(posedge clk);
            #5;
            roll = int'($urandom % 100);
            map_rdy = (roll >= stall_pct);
        end
    end

    // ==================================================
    // Table contents
    // ==================================================
    task automatic set_frame(input int f, input logic [IDX_WIDTH_DEF-1:0] cp, input int stall,
                             input int n, input logic [63:0] m0, m1, m2, m3);
        f_cp[f]    = cp;
        f_stall[f] = stall;
        f_n[f]     = n;
        f_mask[f]  = '{m0, m1, m2, m3};
    endtask

    task automatic fill_table();
        // Every core sees every point
        set_frame(0, 6'h2A, 0, 8, ALL, ALL, ALL, ALL);
        f_cand[0] = '{14'h0A40, 14'h1522, 14'h2331, 14'h3005, 14'h3F77,
                      14'h0122, 14'h2C19, 14'h1260, 14'h0000, 14'h0000};
        // Disjoint ownership, cores 1 to 3 get short lists
        set_frame(1, 6'h11, 0, 10, DISJ, DISJ, DISJ, DISJ);
        f_cand[1] = '{14'h0050, 14'h0140, 14'h0230, 14'h0320, 14'h0410,
                      14'h0870, 14'h0C05, 14'h1033, 14'h1421, 14'h0544};
        // Equal distances
        set_frame(2, 6'h05, 20, 8, ALL, ALL, ALL, ALL);
        f_cand[2] = '{14'h0910, 14'h0310, 14'h1E08, 14'h0710, 14'h2808,
                      14'h1110, 14'h3340, 14'h2A10, 14'h0000, 14'h0000};
        // Heavy stalls, then back-to-back frames on one mask
        set_frame(3, 6'h3C, 60, 10, MIX0, MIX1, MIX2, MIX3);
        f_cand[3] = '{14'h0291, 14'h130A, 14'h2455, 14'h350A, 14'h3EC0,
                      14'h072B, 14'h192B, 14'h2F01, 14'h317E, 14'h0B66};
        set_frame(4, 6'h01, 30, 6, MIX0, MIX1, MIX2, MIX3);
        f_cand[4] = '{14'h3A20, 14'h0511, 14'h2211, 14'h1790, 14'h2E03,
                      14'h0D44, 14'h0000, 14'h0000, 14'h0000, 14'h0000};
        // Far distances equal to the empty entry
        set_frame(5, 6'h3F, 45, 9, MIX0, MIX1, MIX2, MIX3);
        f_cand[5] = '{14'h00FF, 14'h3FFE, 14'h2010, 14'h1010, 14'h3010,
                      14'h0800, 14'h18FF, 14'h2880, 14'h3801, 14'h0000};
    endtask

    // ==================================================
    // Reference model
    // ==================================================
    function automatic logic [IDX_WIDTH_DEF-1:0] point_of(input int f, input int j);
        return f_cand[f][j][CAND_W-1 -: IDX_WIDTH_DEF];
    endfunction

    function automatic logic [DIST_WIDTH_DEF-1:0] dist_of(input int f, input int j);
        return f_cand[f][j][DIST_WIDTH_DEF-1:0];
    endfunction

    function automatic bit in_mask(input int f, input int p, input int core);
        return f_mask[f][p / PTS][NUM_SORT_CORE_DEF*(p % PTS) + core];
    endfunction

    // Stable ascending pick, earliest candidate wins a tie
    function automatic logic [SRAM_WIDTH_DEF-1:0] expected_word(input int f, input int core);
        logic [SRAM_WIDTH_DEF-1:0] w;
        logic [IDX_WIDTH_DEF-1:0]  sel;
        bit                        taken [MAXC];
        int                        best;
        w = '0;
        w[IDX_WIDTH_DEF*SORT_LEN +: IDX_WIDTH_DEF] = f_cp[f];
        for (int j = 0; j < MAXC; j++) begin
            taken[j] = 1'b0;
        end
        for (int k = 0; k < SORT_LEN; k++) begin
            best = -1;
            for (int j = 0; j < f_n[f]; j++) begin
                if (!taken[j] && in_mask(f, int'(point_of(f, j)), core)) begin
                    if (best < 0 || dist_of(f, j) < dist_of(f, best)) begin
                        best = j;
                    end
                end
            end
            // Short list padded with the empty index
            if (best < 0) begin
                sel = '1;
            end else begin
                sel = point_of(f, best);
                taken[best] = 1'b1;
            end
            w[IDX_WIDTH_DEF*k +: IDX_WIDTH_DEF] = sel;
        end
        return w;
    endfunction

    // ==================================================
    // Drivers
    // ==================================================
    task automatic write_mask(input int f);
        for (int a = 0; a < MASK_WORDS; a++) begin
            mask_wr_en   = 1'b1;
            mask_wr_addr = MASK_ADDR_W'(a);
            mask_wr_data = f_mask[f][a];
            @(posedge clk);
            #5;
        end
        mask_wr_en = 1'b0;
    endtask

    // Held until accepted, lop_rdy read mid-cycle
    task automatic send_cand(input int f, input int j);
        int cnt;
        cnt      = 0;
        lop_idx  = point_of(f, j);
        lop_dist = dist_of(f, j);
        lop_last = (j == f_n[f] - 1);
        // Wrong center index on all but the last candidate
        cp_idx   = lop_last ? f_cp[f] : ~f_cp[f];
        lop_vld  = 1'b1;
        @(negedge clk);
        while (!lop_rdy && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!lop_rdy) begin
            $display("Timeout: lop_rdy stayed low for candidate %0d of frame %0d", j, f);
            timeouts++;
        end
        @(posedge clk);
        #5;
    endtask

    // Wait until every expected word has left the DUT
    task automatic drain();
        int cnt;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (chk0.pending() != 0 && cnt < TIMEOUT);
        if (chk0.pending() != 0) begin
            $display("Timeout: %0d map words still outstanding", chk0.pending());
            timeouts++;
        end
        #5;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        bit reload;
        int total;
        rst_n        = 1'b0;
        mask_wr_en   = 1'b0;
        mask_wr_addr = '0;
        mask_wr_data = '0;
        lop_idx      = '0;
        lop_dist     = '0;
        lop_last     = 1'b0;
        cp_idx       = '0;
        lop_vld      = 1'b0;
        fill_table();
        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;

        for (int f = 0; f < NF && timeouts == 0; f++) begin
            // New mask only with the pipeline empty
            reload = (f == 0);
            if (f > 0) begin
                for (int a = 0; a < MASK_WORDS; a++) begin
                    if (f_mask[f][a] != f_mask[f-1][a]) begin
                        reload = 1'b1;
                    end
                end
            end
            if (reload) begin
                drain();
                write_mask(f);
            end
            stall_pct = f_stall[f];
            for (int c = 0; c < NUM_SORT_CORE_DEF; c++) begin
                chk0.expect_word(expected_word(f, c));
            end
            for (int j = 0; j < f_n[f] && timeouts == 0; j++) begin
                send_cand(f, j);
            end
            lop_vld = 1'b0;
        end
        drain();
        chk0.flush_missing();

        total = chk0.errors + timeouts;
        $display("Summary: %0d words checked, %0d word errors, %0d timeouts",
                 chk0.checked, chk0.errors, timeouts);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* src.f */
hw/knn_cfg_pkg.sv
hw/knn_types_pkg.sv
hw/ins_sorter.sv
hw/piso.sv
hw/mask_ram.sv
hw/pss.sv
hw/knn_sort_top.sv
sim/knn_sort_checker.sv
sim/tb_knn_sort.sv

/* Makefile */
# Verilator build and run of the kNN point-selection testbench

VERILATOR ?= verilator
TOP       ?= tb_knn_sort
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= All checks passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
